// ==== inv_config.svh ====
`ifndef INV_CONFIG_SVH
`define INV_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// field sizing
////////////////////////////////////////////////////////////////////////////

// field width, shared by operand a and modulus p
`define INV_W 32

// signed coefficient x1/x2, two guard bits over the field
`define INV_XW (`INV_W + 2)

////////////////////////////////////////////////////////////////////////////
// simulation limits
////////////////////////////////////////////////////////////////////////////

// slack cycles on top of the worst-case latency of all entries
`define INV_TIMEOUT_MARGIN 200

`endif

// ==== inv_pkg.sv ====
`include "inv_config.svh"

package inv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////////////////////////////////////////

    // request as given by the caller
    typedef struct packed {
        logic [`INV_W-1:0] a;             // operand, 1 .. p-1
        logic [`INV_W-1:0] p;             // odd prime modulus
    } inv_req_t;

    // modulus with its shifted copies, registered once per request
    typedef struct packed {
        logic [`INV_W-1:0] p;
        logic [`INV_W-1:0] p_half;        // p >> 1
        logic [`INV_W-1:0] p_quarter;     // p >> 2
    } inv_mod_t;

    // what the core hands over when u or v hits 1
    typedef struct packed {
        logic signed [`INV_XW-1:0] x;     // coefficient, still in -p .. p-1
        logic                      u_won; // 1: from x1, 0: from x2
    } inv_core_res_t;

    ////////////////////////////////////////////////////////////////////////////
    // core control
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        PH_IDLE,
        PH_RUN
    } inv_phase_e;

    typedef enum logic [1:0] {
        STEP_U_HALVE,   // u even
        STEP_V_HALVE,   // v even
        STEP_U_SUB,     // both odd, u >= v
        STEP_V_SUB      // both odd, u < v
    } inv_step_e;

endpackage

// ==== inv_load.sv ====
`timescale 1ns/1ps

module inv_load (
    input  logic              clk,
    input  logic              rstn,
    input  logic              start,
    input  inv_pkg::inv_req_t req,
    output logic              load_vld,
    output inv_pkg::inv_req_t load_req,
    output inv_pkg::inv_mod_t mods
);

    // one-cycle strobe toward the core, a new start always wins
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_vld <= 1'b0;
        end else begin
            load_vld <= start;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request capture
    ////////////////////////////////////////////////////////////////////////////

    // operands go to the core once, the modulus set stays for the whole run
    always_ff @(posedge clk) begin
        if (start) begin
            load_req <= req;
        end
    end

    // p/2 and p/4 are formed here so the halving adders see plain registers
    always_ff @(posedge clk) begin
        if (start) begin
            mods.p         <= req.p;
            mods.p_half    <= req.p >> 1;
            mods.p_quarter <= req.p >> 2;
        end
    end

endmodule

// ==== inv_halve.sv ====
`timescale 1ns/1ps
`include "inv_config.svh"

module inv_halve #(
    parameter int XW = `INV_XW
) (
    input  logic [XW-1:0]     x,
    input  logic              by_four,
    input  inv_pkg::inv_mod_t mods,
    output logic [XW-1:0]     x_out
);

    logic signed [XW-1:0] xs;
    logic [XW-1:0]        sh1;      // floor(x/2)
    logic [XW-1:0]        sh2;      // floor(x/4)
    logic [XW-1:0]        ph1;      // (p+1)/2
    logic [XW-1:0]        pq1;      // floor(p/4)+1
    logic [XW-1:0]        pboth;

    assign xs  = signed'(x);
    assign sh1 = xs >>> 1;
    assign sh2 = xs >>> 2;

    assign ph1 = XW'(mods.p_half) + 1'b1;
    assign pq1 = XW'(mods.p_quarter) + 1'b1;

    // p = 3 mod 4 needs (3p+3)/4 here, p = 1 mod 4 needs (3p+1)/4
    assign pboth = XW'(mods.p_half) + XW'(mods.p_quarter) + (mods.p[1] ? 2'd2 : 2'd1);

    ////////////////////////////////////////////////////////////////////////////
    // x/2 or x/4 mod p, the dropped bits pick how many p to fold in
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!by_four) begin
            x_out = x[0] ? sh1 + ph1 : sh1;   // odd x: (x+p)/2
        end else begin
            case (x[1:0])
                2'b00: x_out = sh2;
                2'b10: x_out = sh2 + ph1;     // (x+2p)/4
                2'b01: begin
                    // x+p or x+3p, whichever is a multiple of 4
                    x_out = mods.p[1] ? sh2 + pq1 : sh2 + pboth;
                end
                default: begin
                    x_out = mods.p[1] ? sh2 + pboth : sh2 + pq1;
                end
            endcase
        end
    end

endmodule

// ==== inv_core.sv ====
`timescale 1ns/1ps
`include "inv_config.svh"

module inv_core (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   load_vld,
    input  inv_pkg::inv_req_t      load_req,
    input  inv_pkg::inv_mod_t      mods,
    output logic                   fin_vld,
    output inv_pkg::inv_core_res_t res,
    output logic                   running
);
    import inv_pkg::*;

    localparam int W  = `INV_W;
    localparam int XW = `INV_XW;

    inv_phase_e           phase;
    inv_step_e            step;
    logic                 fin_q;
    logic [W-1:0]         u;
    logic [W-1:0]         v;
    logic signed [XW-1:0] x1;       // x1*a = u mod p
    logic signed [XW-1:0] x2;       // x2*a = v mod p
    logic                 u_one;
    logic                 v_one;
    logic                 finish;
    logic                 u_by4;
    logic                 v_by4;
    logic [W-1:0]         uv_diff;
    logic [W-1:0]         vu_diff;
    logic signed [XW-1:0] p_ext;
    logic [XW-1:0]        x1_in;
    logic [XW-1:0]        x2_in;
    logic [XW-1:0]        x1_next;
    logic [XW-1:0]        x2_next;
    logic                 x1_by4;
    logic                 x2_by4;

    // pulls a difference of two coefficients back into -p .. p-1
    function automatic logic signed [XW-1:0] fold_diff(
        input logic signed [XW-1:0] d,
        input logic signed [XW-1:0] pm
    );
        logic signed [XW-1:0] r;
        if (d >= pm)
            r = d - pm;
        else if (d < -pm)
            r = d + pm;
        else
            r = d;
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // step decode
    ////////////////////////////////////////////////////////////////////////////

    assign u_one  = (u == W'(1));
    assign v_one  = (v == W'(1));
    assign finish = u_one | v_one;
    assign u_by4  = (u[1:0] == 2'b00);
    assign v_by4  = (v[1:0] == 2'b00);

    always_comb begin
        if (!u[0])
            step = STEP_U_HALVE;
        else if (!v[0])
            step = STEP_V_HALVE;
        else if (u >= v)
            step = STEP_U_SUB;
        else
            step = STEP_V_SUB;
    end

    // odd/odd case, difference is even so one halving always follows
    assign uv_diff = u - v;
    assign vu_diff = v - u;
    assign p_ext   = signed'(XW'(mods.p));

    assign x1_in  = (step == STEP_U_SUB) ? fold_diff(x1 - x2, p_ext) : x1;
    assign x2_in  = (step == STEP_V_SUB) ? fold_diff(x2 - x1, p_ext) : x2;
    assign x1_by4 = (step == STEP_U_HALVE) & u_by4;
    assign x2_by4 = (step == STEP_V_HALVE) & v_by4;

    inv_halve #(.XW(XW)) u_halve_x1 (
        .x       (x1_in),
        .by_four (x1_by4),
        .mods    (mods),
        .x_out   (x1_next)
    );

    inv_halve #(.XW(XW)) u_halve_x2 (
        .x       (x2_in),
        .by_four (x2_by4),
        .mods    (mods),
        .x_out   (x2_next)
    );

    ////////////////////////////////////////////////////////////////////////////
    // control and iteration registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase <= PH_IDLE;
            fin_q <= 1'b0;
        end else begin
            fin_q <= 1'b0;
            if (load_vld) begin
                phase <= PH_RUN;              // also restarts a busy run
            end else if (phase == PH_RUN && finish) begin
                phase <= PH_IDLE;
                fin_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_vld) begin
            u  <= load_req.a;
            v  <= load_req.p;
            x1 <= XW'(1);
            x2 <= '0;
        end else if (phase == PH_RUN && !finish) begin
            case (step)
                STEP_U_HALVE: begin
                    u  <= u_by4 ? u >> 2 : u >> 1;
                    x1 <= signed'(x1_next);
                end
                STEP_V_HALVE: begin
                    v  <= v_by4 ? v >> 2 : v >> 1;
                    x2 <= signed'(x2_next);
                end
                STEP_U_SUB: begin
                    u  <= uv_diff >> 1;
                    x1 <= signed'(x1_next);
                end
                default: begin
                    v  <= vu_diff >> 1;
                    x2 <= signed'(x2_next);
                end
            endcase
        end
    end

    // u is checked first when both reach 1 together
    always_ff @(posedge clk) begin
        if (phase == PH_RUN && finish) begin
            res.x     <= u_one ? x1 : x2;
            res.u_won <= u_one;
        end
    end

    assign fin_vld = fin_q & ~load_vld;       // a fresh load drops the old result
    assign running = (phase == PH_RUN);

endmodule

// ==== inv_reduce.sv ====
`timescale 1ns/1ps
`include "inv_config.svh"

module inv_reduce (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   fin_vld,
    input  inv_pkg::inv_core_res_t res,
    input  logic [`INV_W-1:0]      p,
    output logic                   done,
    output logic [`INV_W-1:0]      result
);

    localparam int W  = `INV_W;
    localparam int XW = `INV_XW;

    logic signed [XW-1:0] x;
    logic signed [XW-1:0] p_ext;
    logic signed [XW-1:0] x_corr;

    assign x     = signed'(res.x);
    assign p_ext = signed'(XW'(p));

    // one add or subtract of p brings the coefficient into 0 .. p-1
    always_comb begin
        if (x < 0)
            x_corr = x + p_ext;
        else if (x >= p_ext)
            x_corr = x - p_ext;
        else
            x_corr = x;
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register, result held until the next done
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= fin_vld;
            if (fin_vld) begin
                result <= x_corr[W-1:0];
            end
        end
    end

endmodule

// ==== inv_top.sv ====
`timescale 1ns/1ps
`include "inv_config.svh"

module inv_top (
    input  logic              clk,
    input  logic              rstn,
    input  logic              start,
    input  inv_pkg::inv_req_t req,
    output logic              done,
    output logic              busy,
    output logic [`INV_W-1:0] result
);
    import inv_pkg::*;

    logic          load_vld;
    inv_req_t      load_req;
    inv_mod_t      mods;        // held in the load stage for the whole run
    logic          fin_vld;
    inv_core_res_t res;
    logic          running;

    inv_load u_load (
        .clk      (clk),
        .rstn     (rstn),
        .start    (start),
        .req      (req),
        .load_vld (load_vld),
        .load_req (load_req),
        .mods     (mods)
    );

    inv_core u_core (
        .clk      (clk),
        .rstn     (rstn),
        .load_vld (load_vld),
        .load_req (load_req),
        .mods     (mods),
        .fin_vld  (fin_vld),
        .res      (res),
        .running  (running)
    );

    inv_reduce u_reduce (
        .clk     (clk),
        .rstn    (rstn),
        .fin_vld (fin_vld),
        .res     (res),
        .p       (mods.p),
        .done    (done),
        .result  (result)
    );

    // covers load, iteration, hand-over and the done cycle
    assign busy = load_vld | running | fin_vld | done;

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset released just after an edge, same as the other inputs
    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

// ==== tb_inv_top.sv ====
`timescale 1ns/1ps
`include "inv_config.svh"

module tb_inv_top;
    import inv_pkg::*;

    localparam int W          = `INV_W;
    localparam int N_PRIME    = 4;
    localparam int N_RAND     = 4;                      // random operands per prime
    localparam int N_ENTRY    = N_PRIME * (3 + N_RAND);
    localparam int RUN_CYCLES = 2 * W + 5;              // start sample to done, worst case
    localparam int N_RUNS     = N_ENTRY + 3;            // table, restart pair, quiet window
    localparam int TIMEOUT_CYCLES = N_RUNS * RUN_CYCLES + `INV_TIMEOUT_MARGIN;

    typedef struct packed {
        logic [W-1:0] a;
        logic [W-1:0] p;
        logic [W-1:0] exp;
    } stim_t;

    logic         clk;
    logic         rstn;
    logic         start;
    inv_req_t     req;
    logic         done;
    logic         busy;
    logic [W-1:0] result;

    stim_t        stim_tab [N_ENTRY];
    logic [W-1:0] last_result;
    integer       seed = 32'h83ddeee4;
    int           cycle_cnt = 0;

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    inv_top UUT (
        .clk    (clk),
        .rstn   (rstn),
        .start  (start),
        .req    (req),
        .done   (done),
        .busy   (busy),
        .result (result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model and checking
    ////////////////////////////////////////////////////////////////////////////

    // integer extended Euclid, t tracks the coefficient of a
    function automatic logic [W-1:0] ref_inverse(input logic [W-1:0] a, input logic [W-1:0] p);
        longint t;
        longint new_t;
        longint r;
        longint new_r;
        longint q;
        longint tmp;
        t     = 0;
        new_t = 1;
        r     = longint'(p);
        new_r = longint'(a);
        while (new_r != 0) begin
            q     = r / new_r;
            tmp   = t - q * new_t;
            t     = new_t;
            new_t = tmp;
            tmp   = r - q * new_r;
            r     = new_r;
            new_r = tmp;
        end
        if (t < 0)
            t = t + longint'(p);
        return t[W-1:0];
    endfunction

    function automatic logic [63:0] mul_mod(input logic [W-1:0] a, input logic [W-1:0] b,
                                            input logic [W-1:0] p);
        logic [63:0] prod;
        prod = 64'(a) * 64'(b);
        return prod % 64'(p);
    endfunction

    function automatic stim_t make_entry(input logic [W-1:0] a, input logic [W-1:0] p);
        stim_t s;
        s.a   = a;
        s.p   = p;
        s.exp = ref_inverse(a, p);
        return s;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping on first error");
        end
    endtask

    // edge operands first, then random ones, for every prime
    task automatic fill_table();
        logic [W-1:0] primes [N_PRIME];
        logic [W-1:0] p;
        logic [W-1:0] r;
        int           k;
        primes[0] = 32'd4294967291;
        primes[1] = 32'd2147483647;
        primes[2] = 32'd65521;
        primes[3] = 32'd13;
        k = 0;
        for (int i = 0; i < N_PRIME; i++) begin
            p = primes[i];
            stim_tab[k]     = make_entry(1, p);
            stim_tab[k + 1] = make_entry(p - 1, p);
            stim_tab[k + 2] = make_entry(2, p);
            k = k + 3;
            for (int j = 0; j < N_RAND; j++) begin
                r = $random(seed);
                stim_tab[k] = make_entry(r % (p - 1) + 1, p);   // a in 1 .. p-1
                k = k + 1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////////////////////

    // pulses start for one cycle, returns just after the sampling edge
    task automatic issue_start(input logic [W-1:0] a, input logic [W-1:0] p);
        @(posedge clk);
        #1;
        start = 1'b1;
        req.a = a;
        req.p = p;
        @(negedge clk);
        check_value(done, 0, "done high for more than one cycle");
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // watches busy and the held result until done, bounded by the latency limit
    task automatic wait_done();
        int   lat;
        logic seen;
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < RUN_CYCLES) begin
            @(negedge clk);
            lat  = lat + 1;
            seen = done;
            if (!seen) begin
                check_value(busy, 1, "busy low during a run");
                check_value(result, last_result, "result changed before done");
            end
        end
        check_value(seen, 1, "done within 2*W+5 cycles of start");
        check_value(busy, 1, "busy low in the done cycle");
    endtask

    task automatic check_result(input logic [W-1:0] a, input logic [W-1:0] p,
                                input logic [W-1:0] exp);
        check_value(result, exp, $sformatf("inverse of a=%0d mod p=%0d", a, p));
        check_value(mul_mod(a, result, p), 1, $sformatf("a*result mod p for a=%0d", a));
        last_result = result;
    endtask

    task automatic run_entry(input stim_t s);
        issue_start(s.a, s.p);
        wait_done();
        check_result(s.a, s.p, s.exp);
    endtask

    // second start lands a few cycles into the first run
    task automatic restart_run();
        logic [W-1:0] p;
        logic [W-1:0] a1;
        logic [W-1:0] a2;
        p  = 32'd4294967291;
        a1 = 32'd123456789;
        a2 = 32'd987654321;
        issue_start(a1, p);
        repeat (3) begin
            @(negedge clk);
            check_value(done, 0, "done from the discarded run");
            check_value(busy, 1, "busy low while the first run is going");
        end
        issue_start(a2, p);
        wait_done();
        check_result(a2, p, ref_inverse(a2, p));
    endtask

    task automatic quiet_window();
        repeat (RUN_CYCLES + 5) begin
            @(negedge clk);
            check_value(done, 0, "extra done after the restart");
            check_value(busy, 0, "busy high with no request");
            check_value(result, last_result, "result changed without done");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        start       = 1'b0;
        req         = '0;
        last_result = '0;
        fill_table();
        wait (rstn === 1'b1);
        @(negedge clk);
        check_value(done, 0, "done after reset");
        check_value(busy, 0, "busy after reset");
        check_value(result, 0, "result after reset");
        // each start comes in the cycle right after the previous done
        for (int i = 0; i < N_ENTRY; i++) begin
            run_entry(stim_tab[i]);
        end
        restart_run();
        quiet_window();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
inv_pkg.sv
inv_load.sv
inv_halve.sv
inv_core.sv
inv_reduce.sv
inv_top.sv
tb_clk_gen.sv
tb_inv_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the inverter testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_inv_top -o sim_inv &&
out="$(./obj_dir/sim_inv)"
echo "$out"
echo "$out" | grep -q -F "*** TEST PASSED ***" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
